//--- test/pmp_stimulus.txt
# columns: op test a b c expect (test in decimal, rest hex); write/read a=csr b=wdata
# fetch/data a=addr b=flags {mxr,req,m_mode,write or 32bit}; sweep a=base b=rand mask c=count
write 1 3a0 196f1c16 0 0
write 1 3b0 00000401 0 0
write 1 3b1 c00005ff 0 0
write 1 3b2 ffffffff 0 0
write 1 3b3 00000803 0 0
read 1 3a0 0 0 19071c16
read 1 3b1 0 0 000005ff
read 1 3b2 0 0 3fffffff
data 2 00001008 0 0 0
data 2 00001008 1 0 1
data 2 00001004 1 0 0
data 2 00000ffc 0 0 1
data 2 00002010 0 0 1
data 2 00002010 8 0 0
data 3 00001008 3 0 0
write 3 3a0 196f9c16 0 0
read 3 3a0 0 0 19079c16
data 3 00001008 3 0 1
data 3 00001008 2 0 0
fetch 4 0000201e 1 0 1
fetch 4 0000201e 0 0 0
fetch 4 0000201c 1 0 0
sweep 5 00000000 00003fff 30 0
data 6 00000ffc 4 0 1
fetch 6 0000201e 5 0 1
read 6 bc1 0 0 00000001
read 6 bc0 0 0 00000ffc
read 6 bc2 0 0 00000002
write 6 bc1 0 0 0
write 6 bc2 0 0 0
read 6 bc1 0 0 00000000
read 6 bc2 0 0 00000000

//--- pmp_top.f
+incdir+include
hdl/pmp_pkg.sv
hdl/pmp_regs.sv
hdl/pmp_match.sv
hdl/pmp_fault_fsm.sv
hdl/pmp_fault_counter.sv
hdl/pmp_top.sv
test/tb_clkgen.sv
test/pmp_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile the pmp checker testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f pmp_top.f --top-module pmp_top_tb -o pmp_sim

out=$(./obj_dir/pmp_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TESTS PASSED"; then
	exit 0
fi
exit 1

//--- test/pmp_top_tb.sv
// pmp checker testbench: replays the stimulus file against the DUT and checks every response
`default_nettype none
`include "pmp_cfg.svh"

module pmp_top_tb;
	import pmp_pkg::*;

	// one operation from the stimulus file
	typedef struct packed {
		logic [63:0] op;
		logic [7:0]  test;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] exp;
	} stim_t;

	logic         clk;
	logic         rst_n;
	logic [11:0]  csr_addr;
	logic         csr_wen;
	logic [31:0]  csr_wdata;
	logic [31:0]  csr_rdata;
	pmp_fetch_q_t fetch_q;
	pmp_data_q_t  data_q;
	logic         mxr;
	logic         i_kill;
	logic         d_kill;

	stim_t stim[$];
	int    err_cnt;
	int    chk_cnt;
	int    test_err;
	int    test_chk;
	int    test_cnt;
	int    wd_limit = 0;

	// shadow copy of the region registers as software sees them
	logic [7:0]  sh_cfg[`PMP_REGIONS];
	logic [29:0] sh_addr[`PMP_REGIONS];

	tb_clkgen #(.PERIOD(8), .RST_CYCLES(5)) u_clkgen (
		.o_clk   (clk),
		.o_rst_n (rst_n)
	);

	pmp_top uut (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_csr_addr  (csr_addr),
		.i_csr_wen   (csr_wen),
		.i_csr_wdata (csr_wdata),
		.o_csr_rdata (csr_rdata),
		.i_fetch     (fetch_q),
		.i_data      (data_q),
		.i_mxr       (mxr),
		.o_i_kill    (i_kill),
		.o_d_kill    (d_kill)
	);

	// ----------------------------------------
	// helpers

	task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
		chk_cnt++;
		test_chk++;
		if (got !== exp) begin
			$display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
			err_cnt++;
			test_err++;
		end
	endtask

	task automatic idle_inputs();
		csr_wen   = 1'b0;
		csr_addr  = 12'h000;
		csr_wdata = 32'd0;
		fetch_q   = '0;
		data_q    = '0;
		mxr       = 1'b0;
	endtask

	// every operation starts just after a rising edge with the ports idle
	task automatic start_cycle();
		@(posedge clk);
		#1;
		idle_inputs();
	endtask

	// follow a csr write in the shadow, tor lands as off and reserved bits drop
	task automatic track_write(input logic [11:0] addr, input logic [31:0] wdata);
		logic [7:0] cfg;
		for (int i = 0; i < `PMP_REGIONS; i++) begin
			if (addr == 12'(`PMP_CSR_PMPCFG0 + i / 4)) begin
				cfg = wdata[8 * (i % 4) +: 8];
				cfg[6:5] = 2'b00;
				if (cfg[4:3] == 2'b01) begin
					cfg[4:3] = 2'b00;
				end
				sh_cfg[i] = cfg;
			end
			if (addr == 12'(`PMP_CSR_PMPADDR0 + i)) begin
				sh_addr[i] = wdata[29:0];
			end
		end
	endtask

	// expected kill of a user-mode load/store, the first matching region decides
	function automatic logic expect_dkill(input logic [31:0] addr, input logic wr);
		logic [63:0] size;
		logic        hit;
		logic        found;
		logic        kill;
		int          ones;
		found = 1'b0;
		kill  = 1'b1;
		for (int i = 0; i < `PMP_REGIONS; i++) begin
			hit = 1'b0;
			if (sh_cfg[i][4:3] == 2'b10) begin
				hit = (addr[31:2] == sh_addr[i]);
			end else if (sh_cfg[i][4:3] == 2'b11) begin
				// a napot region is 8 bytes, doubled for every trailing one of pmpaddr
				ones = 0;
				while (ones < 30 && sh_addr[i][ones]) begin
					ones++;
				end
				size = 64'd8 << ones;
				hit = ({32'd0, addr} / size) == ({32'd0, sh_addr[i], 2'b00} / size);
			end
			if (hit && !found) begin
				found = 1'b1;
				kill  = wr ? !sh_cfg[i][1] : !sh_cfg[i][2];
			end
		end
		return kill;
	endfunction

	task automatic load_stimulus();
		int               fd;
		int               n;
		logic [63:0]      op;
		logic [8*128-1:0] rest;
		logic [7:0]       t;
		logic [31:0]      a;
		logic [31:0]      b;
		logic [31:0]      c;
		logic [31:0]      e;
		stim_t            s;
		fd = $fopen("test/pmp_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file test/pmp_stimulus.txt");
			err_cnt++;
		end else begin
			while ($fscanf(fd, "%s", op) == 1) begin
				if (op == "#") begin
					n = $fgets(rest, fd);
				end else begin
					n = $fscanf(fd, "%d %h %h %h %h", t, a, b, c, e);
					if (n != 5) begin
						$display("stimulus line %0d is missing fields", stim.size() + 1);
						err_cnt++;
					end
					s = '{op: op, test: t, a: a, b: b, c: c, exp: e};
					stim.push_back(s);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic report_test(input logic [7:0] id);
		test_cnt++;
		$display("test %0d %s: %0d checks, %0d errors", id,
			(test_err == 0) ? "ok" : "failed", test_chk, test_err);
		test_chk = 0;
		test_err = 0;
	endtask

	// ----------------------------------------
	// one stimulus operation

	task automatic run_op(input stim_t s);
		logic [31:0] addr;
		logic [31:0] rnd;
		start_cycle();
		if (s.op == "write") begin
			// the write lands on the next edge, when the next operation starts
			csr_addr  = s.a[11:0];
			csr_wdata = s.b;
			csr_wen   = 1'b1;
			track_write(s.a[11:0], s.b);
		end else if (s.op == "read") begin
			csr_addr = s.a[11:0];
			#5;
			compare(csr_rdata, s.exp, $sformatf("csr %h read", s.a[11:0]));
		end else if (s.op == "fetch") begin
			fetch_q.addr     = s.a;
			fetch_q.is_32bit = s.b[0];
			fetch_q.m_mode   = s.b[1];
			fetch_q.req      = s.b[2];
			#5;
			compare({31'd0, i_kill}, s.exp, $sformatf("fetch kill at %h", s.a));
		end else if (s.op == "data") begin
			data_q.addr   = s.a;
			data_q.write  = s.b[0];
			data_q.m_mode = s.b[1];
			data_q.req    = s.b[2];
			mxr           = s.b[3];
			#5;
			compare({31'd0, d_kill}, s.exp, $sformatf("data kill at %h", s.a));
		end else if (s.op == "sweep") begin
			// user-mode lookups without a request, so the fault bookkeeping stays still
			for (int n = 0; n < s.c; n++) begin
				if (n != 0) begin
					start_cycle();
				end
				addr = s.a | ($urandom & s.b);
				rnd  = $urandom;
				data_q.addr  = addr;
				data_q.write = rnd[0];
				#5;
				compare({31'd0, d_kill}, {31'd0, expect_dkill(addr, rnd[0])},
					$sformatf("sweep data kill at %h", addr));
			end
		end else begin
			$display("unknown operation in the stimulus file, test %0d", s.test);
			err_cnt++;
		end
	endtask

	// ----------------------------------------
	// main sequence and watchdog

	initial begin
		logic [7:0] cur_test;
		err_cnt  = 0;
		chk_cnt  = 0;
		test_err = 0;
		test_chk = 0;
		test_cnt = 0;
		for (int i = 0; i < `PMP_REGIONS; i++) begin
			sh_cfg[i]  = 8'd0;
			sh_addr[i] = 30'd0;
		end
		idle_inputs();
		void'($urandom(32'h3666));
		load_stimulus();
		wd_limit = stim.size() * 8 * 4 + 400;
		@(posedge rst_n);
		cur_test = (stim.size() != 0) ? stim[0].test : 8'd0;
		foreach (stim[k]) begin
			if (stim[k].test != cur_test) begin
				report_test(cur_test);
				cur_test = stim[k].test;
			end
			run_op(stim[k]);
		end
		if (stim.size() != 0) begin
			report_test(cur_test);
		end
		$display("%0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		wait (wd_limit != 0);
		#(wd_limit);
		$display("timeout: the run did not finish within %0d time units", wd_limit);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/tb_clkgen.sv
// testbench clock and reset source: free-running clock plus a power-on reset pulse
`default_nettype none

module tb_clkgen #(
	parameter int PERIOD     = 8,
	parameter int RST_CYCLES = 5
) (
	output logic o_clk,
	output logic o_rst_n
);

	initial begin
		o_clk = 1'b0;
		forever begin
			#(PERIOD / 2);
			o_clk = ~o_clk;
		end
	end

	// reset is released just after an edge so it never lands on one
	initial begin
		o_rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge o_clk);
		#1;
		o_rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- hdl/pmp_top.sv
// pmp checker top: register file, region matcher, fault tracker and fault counter
`default_nettype none
`include "pmp_cfg.svh"

module pmp_top (
	input  wire logic                   clk,
	input  wire logic                   rst_n,
	// csr strobe port
	input  wire logic [11:0]            i_csr_addr,
	input  wire logic                   i_csr_wen,
	input  wire logic [`PMP_W_DATA-1:0] i_csr_wdata,
	output wire logic [`PMP_W_DATA-1:0] o_csr_rdata,
	// query ports, answered in the same cycle
	input  wire pmp_pkg::pmp_fetch_q_t  i_fetch,
	input  wire pmp_pkg::pmp_data_q_t   i_data,
	input  wire logic                   i_mxr,
	output wire logic                   o_i_kill,
	output wire logic                   o_d_kill
);
	import pmp_pkg::*;

	pmp_region_cfg_t [`PMP_REGIONS-1:0]      region_cfg;
	logic [`PMP_REGIONS-1:0][`PMP_W_ADDR-3:0] region_addr;
	pmp_fault_rec_t                          fault_rec;
	logic [`PMP_CNT_W-1:0]                   fault_cnt;
	logic                                    fault_clr;
	logic                                    cnt_clr;
	// qualified kills, shared by the tracker and the counter
	logic                                    i_fault;
	logic                                    d_fault;

	pmp_regs u_regs (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_csr_addr    (i_csr_addr),
		.i_csr_wen     (i_csr_wen),
		.i_csr_wdata   (i_csr_wdata),
		.o_csr_rdata   (o_csr_rdata),
		.o_region_cfg  (region_cfg),
		.o_region_addr (region_addr),
		.i_fault_rec   (fault_rec),
		.i_fault_cnt   (fault_cnt),
		.o_fault_clr   (fault_clr),
		.o_cnt_clr     (cnt_clr)
	);

	pmp_match u_match (
		.i_region_cfg  (region_cfg),
		.i_region_addr (region_addr),
		.i_fetch       (i_fetch),
		.i_data        (i_data),
		.i_mxr         (i_mxr),
		.o_i_kill      (o_i_kill),
		.o_d_kill      (o_d_kill),
		.o_i_fault     (i_fault),
		.o_d_fault     (d_fault)
	);

	// the tracker takes the raw query addresses straight from the ports
	pmp_fault_fsm u_fault_fsm (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_i_fault   (i_fault),
		.i_d_fault   (d_fault),
		.i_i_addr    (i_fetch.addr),
		.i_d_addr    (i_data.addr),
		.i_clr       (fault_clr),
		.o_fault_rec (fault_rec)
	);

	pmp_fault_counter u_fault_counter (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_i_fault (i_fault),
		.i_d_fault (d_fault),
		.i_clr     (cnt_clr),
		.o_count   (fault_cnt)
	);

endmodule

`default_nettype wire

//--- hdl/pmp_fault_counter.sv
// saturating counter of killed accesses, up to two per cycle, with synchronous clear
`default_nettype none
`include "pmp_cfg.svh"

module pmp_fault_counter (
	input  wire logic                  clk,
	input  wire logic                  rst_n,
	input  wire logic                  i_i_fault,
	input  wire logic                  i_d_fault,
	input  wire logic                  i_clr,
	output logic [`PMP_CNT_W-1:0]      o_count
);

	localparam int W = `PMP_CNT_W;

	// one spare bit catches the carry out of the add
	logic [W:0] sum;

	assign sum = {1'b0, o_count} + {{W{1'b0}}, i_i_fault} + {{W{1'b0}}, i_d_fault};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_count <= '0;
		end else if (i_clr) begin
			// clear wins over a same-cycle increment
			o_count <= '0;
		end else if (sum[W]) begin
			o_count <= '1;
		end else begin
			o_count <= sum[W-1:0];
		end
	end

	// the count only moves down through a clear
	assert property (@(posedge clk) disable iff (!rst_n) !i_clr |=> o_count >= $past(o_count))
		else $error("fault count dropped without a clear");

endmodule

`default_nettype wire

//--- hdl/pmp_fault_fsm.sv
// fault tracker: captures the first killed access and holds it until software clears it
`default_nettype none
`include "pmp_cfg.svh"

module pmp_fault_fsm (
	input  wire logic                   clk,
	input  wire logic                   rst_n,
	input  wire logic                   i_i_fault,
	input  wire logic                   i_d_fault,
	input  wire logic [`PMP_W_ADDR-1:0] i_i_addr,
	input  wire logic [`PMP_W_ADDR-1:0] i_d_addr,
	input  wire logic                   i_clr,
	output pmp_pkg::pmp_fault_rec_t     o_fault_rec
);

	typedef enum logic {
		ST_IDLE = 1'b0,
		ST_HELD = 1'b1
	} state_e;

	state_e                 state;
	state_e                 state_nxt;
	logic                   capture;
	logic                   rec_is_fetch;
	logic [`PMP_W_ADDR-1:0] rec_addr;

	// only a fault seen while idle is recorded, later ones are dropped
	assign capture = (state == ST_IDLE) && (i_i_fault || i_d_fault);

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (capture) begin
					state_nxt = ST_HELD;
				end
			end
			ST_HELD: begin
				if (i_clr) begin
					state_nxt = ST_IDLE;
				end
			end
			default: begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// a fetch fault wins when both ports fault in the same cycle
	always_ff @(posedge clk) begin
		if (capture) begin
			rec_is_fetch <= i_i_fault;
			rec_addr     <= i_i_fault ? i_i_addr : i_d_addr;
		end
	end

	// software sees a valid record exactly while the tracker is holding
	assign o_fault_rec.valid    = (state == ST_HELD);
	assign o_fault_rec.is_fetch = rec_is_fetch;
	assign o_fault_rec.addr     = rec_addr;

	// kills that arrive while holding leave the captured record alone
	assert property (@(posedge clk) disable iff (!rst_n)
		(state == ST_HELD) && !i_clr |=> $stable(o_fault_rec))
		else $error("fault record changed while the tracker was holding");

endmodule

`default_nettype wire

//--- hdl/pmp_match.sv
// pmp region matcher: mask decode, lowest-region priority and kill rules for fetch and data
`default_nettype none
`include "pmp_cfg.svh"

module pmp_match (
	input  wire pmp_pkg::pmp_region_cfg_t [`PMP_REGIONS-1:0] i_region_cfg,
	input  wire logic [`PMP_REGIONS-1:0][`PMP_W_ADDR-3:0]    i_region_addr,
	input  wire pmp_pkg::pmp_fetch_q_t                       i_fetch,
	input  wire pmp_pkg::pmp_data_q_t                        i_data,
	input  wire logic                                        i_mxr,
	output logic                                             o_i_kill,
	output logic                                             o_d_kill,
	output logic                                             o_i_fault,
	output logic                                             o_d_fault
);
	import pmp_pkg::*;

	logic [`PMP_REGIONS-1:0][`PMP_W_ADDR-1:0] match_mask;
	logic [`PMP_REGIONS-1:0][`PMP_W_ADDR-1:0] match_base;
	logic [`PMP_REGIONS-1:0]                  region_on;
	logic [`PMP_W_ADDR-1:0]                   i_addr_hw1;

	// attributes of the winning region per port
	logic d_l;
	logic d_r;
	logic d_w;
	logic d_x;
	logic i_l;
	logic i_x;
	logic i_partial;

	// ----------------------------------------
	// region decode

	// na4 compares every bit above bit 1
	// napot compares every bit above the lowest zero of pmpaddr, so
	// y..y0 is 8 bytes, y..y01 is 16 bytes and so on
	always_comb begin
		for (int i = 0; i < `PMP_REGIONS; i++) begin
			region_on[i] = (i_region_cfg[i].a == PMP_A_NA4) ||
				(i_region_cfg[i].a == PMP_A_NAPOT);
			if (i_region_cfg[i].a == PMP_A_NA4) begin
				match_mask[i] = {{(`PMP_W_ADDR - 2){1'b1}}, 2'b00};
			end else begin
				// bit 2 stays clear since napot is at least 8 bytes
				match_mask[i] = '0;
				for (int j = 3; j < `PMP_W_ADDR; j++) begin
					match_mask[i][j] = match_mask[i][j - 1] | ~i_region_addr[i][j - 3];
				end
			end
			match_base[i] = {i_region_addr[i], 2'b00} & match_mask[i];
		end
	end

	// ----------------------------------------
	// data lookup

	// misaligned data accesses trap elsewhere, so only the first byte is checked
	// walking down from the top leaves the lowest-numbered hit in place
	always_comb begin
		d_l = 1'b0;
		d_r = 1'b0;
		d_w = 1'b0;
		d_x = 1'b0;
		for (int i = `PMP_REGIONS - 1; i >= 0; i--) begin
			if (region_on[i] && ((i_data.addr & match_mask[i]) == match_base[i])) begin
				d_l = i_region_cfg[i].l;
				d_r = i_region_cfg[i].r;
				d_w = i_region_cfg[i].w;
				d_x = i_region_cfg[i].x;
			end
		end
	end

	// ----------------------------------------
	// fetch lookup

	// both halfwords of a possible 32-bit instruction are looked up
	assign i_addr_hw1 = i_fetch.addr + `PMP_W_ADDR'(2);

	// a region that covers only one halfword of a 32-bit fetch is a partial match,
	// which fails unless a lower region covers both halfwords
	always_comb begin
		logic hw0;
		logic hw1;
		i_l = 1'b0;
		i_x = 1'b0;
		i_partial = 1'b0;
		for (int i = `PMP_REGIONS - 1; i >= 0; i--) begin
			hw0 = region_on[i] && ((i_fetch.addr & match_mask[i]) == match_base[i]);
			hw1 = region_on[i] && ((i_addr_hw1 & match_mask[i]) == match_base[i]);
			if (hw0 || hw1) begin
				i_l = i_region_cfg[i].l;
				i_x = i_region_cfg[i].x;
				i_partial = (hw0 ^ hw1) && i_fetch.is_32bit;
			end
		end
	end

	// ----------------------------------------
	// kill rules

	// m-mode passes unless the region is locked; no match leaves every attribute clear
	// mxr lets loads read from execute-only regions
	assign o_d_kill = !(i_data.m_mode && !d_l) && (
		(!i_data.write && !(d_r || (d_x && i_mxr))) ||
		( i_data.write && !d_w));

	// a straddling fetch is killed whatever the mode
	assign o_i_kill = i_partial || (!(i_fetch.m_mode && !i_l) && !i_x);

	// faults are kills of real requests, everything else is just a lookup
	assign o_i_fault = o_i_kill && i_fetch.req;
	assign o_d_fault = o_d_kill && i_data.req;

endmodule

`default_nettype wire

//--- hdl/pmp_regs.sv
// pmp csr register file: pmpcfg and pmpaddr storage, read mux and fault clear strobes
`default_nettype none
`include "pmp_cfg.svh"

module pmp_regs (
	input  wire logic                                        clk,
	input  wire logic                                        rst_n,
	input  wire logic [11:0]                                 i_csr_addr,
	input  wire logic                                        i_csr_wen,
	input  wire pmp_pkg::pmp_csr_word_u                      i_csr_wdata,
	output logic [`PMP_W_DATA-1:0]                           o_csr_rdata,
	output pmp_pkg::pmp_region_cfg_t [`PMP_REGIONS-1:0]      o_region_cfg,
	output logic [`PMP_REGIONS-1:0][`PMP_W_ADDR-3:0]         o_region_addr,
	input  wire pmp_pkg::pmp_fault_rec_t                     i_fault_rec,
	input  wire logic [`PMP_CNT_W-1:0]                       i_fault_cnt,
	output logic                                             o_fault_clr,
	output logic                                             o_cnt_clr
);
	import pmp_pkg::*;

	// each pmpcfg word covers four regions
	localparam int CFG_WORDS = `PMP_REGIONS / 4;

	pmp_csr_word_u rd_word;

	// reserved bits are dropped and tor is folded onto off before storage
	function automatic pmp_region_cfg_t legalize(input pmp_region_cfg_t raw);
		pmp_region_cfg_t cfg;
		cfg = raw;
		cfg.rsvd = 2'b00;
		if (raw.a == PMP_A_TOR) begin
			cfg.a = PMP_A_OFF;
		end
		return cfg;
	endfunction

	// ----------------------------------------
	// write decode

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			// every region comes up off
			o_region_cfg  <= '0;
			o_region_addr <= '0;
		end else if (i_csr_wen) begin
			for (int i = 0; i < `PMP_REGIONS; i++) begin
				// region i lives in byte i%4 of pmpcfg word i/4
				if (i_csr_addr == 12'(`PMP_CSR_PMPCFG0 + i / 4)) begin
					o_region_cfg[i] <= legalize(i_csr_wdata.cfg[i % 4]);
				end
				// the pad bits stand for address bits 33:32 and are thrown away
				if (i_csr_addr == 12'(`PMP_CSR_PMPADDR0 + i)) begin
					o_region_addr[i] <= i_csr_wdata.addr_w.addr;
				end
			end
		end
	end

	// the clears are single-cycle because the write strobe itself is single-cycle
	assign o_fault_clr = i_csr_wen && (i_csr_addr == `PMP_CSR_FAULT_INFO);
	assign o_cnt_clr   = i_csr_wen && (i_csr_addr == `PMP_CSR_FAULT_CNT);

	// ----------------------------------------
	// read mux

	always_comb begin
		rd_word = '0;
		// pmpcfg words, packed back four bytes at a time
		for (int k = 0; k < CFG_WORDS; k++) begin
			if (i_csr_addr == 12'(`PMP_CSR_PMPCFG0 + k)) begin
				for (int j = 0; j < 4; j++) begin
					rd_word.cfg[j] = o_region_cfg[4 * k + j];
				end
			end
		end
		// pmpaddr words, upper pad reads as zero
		for (int i = 0; i < `PMP_REGIONS; i++) begin
			if (i_csr_addr == 12'(`PMP_CSR_PMPADDR0 + i)) begin
				rd_word.addr_w.addr = o_region_addr[i];
			end
		end
		// fault bookkeeping words
		case (i_csr_addr)
			`PMP_CSR_FAULT_ADDR: begin
				rd_word = i_fault_rec.addr;
			end
			`PMP_CSR_FAULT_INFO: begin
				// bit 0 is valid, bit 1 tells fetch from load/store
				rd_word = {{(`PMP_W_DATA - 2){1'b0}}, i_fault_rec.is_fetch, i_fault_rec.valid};
			end
			`PMP_CSR_FAULT_CNT: begin
				rd_word = {{(`PMP_W_DATA - `PMP_CNT_W){1'b0}}, i_fault_cnt};
			end
			default: begin
			end
		endcase
	end

	assign o_csr_rdata = rd_word;

	// a stored region byte never holds tor or a set reserved bit
	for (genvar g = 0; g < `PMP_REGIONS; g++) begin : g_cfg_legal
		assert property (@(posedge clk) disable iff (!rst_n)
			(o_region_cfg[g].a != PMP_A_TOR) && (o_region_cfg[g].rsvd == 2'b00))
			else $error("region %0d holds an illegal config byte", g);
	end

endmodule

`default_nettype wire

//--- hdl/pmp_pkg.sv
// shared types for the pmp checker: region config, csr word views, queries, fault record
`default_nettype none
`include "pmp_cfg.svh"

package pmp_pkg;

	// region address matching mode, encoded as in the privileged spec
	typedef enum logic [1:0] {
		PMP_A_OFF   = 2'b00,
		// accepted on the bus but never stored, writes fall back to off
		PMP_A_TOR   = 2'b01,
		PMP_A_NA4   = 2'b10,
		PMP_A_NAPOT = 2'b11
	} pmp_a_e;

	// one region byte of a pmpcfg word, msb first
	typedef struct packed {
		logic   l;
		logic   [1:0] rsvd;
		pmp_a_e a;
		logic   r;
		logic   w;
		logic   x;
	} pmp_region_cfg_t;

	// a csr data word is either four region bytes or a region address
	// the address view holds bits 33:2, and the top two of those are not implemented
	typedef union packed {
		pmp_region_cfg_t [3:0] cfg;
		struct packed {
			logic [1:0]             pad;
			logic [`PMP_W_ADDR-3:0] addr;
		} addr_w;
	} pmp_csr_word_u;

	// instruction fetch query
	typedef struct packed {
		logic                   req;
		logic [`PMP_W_ADDR-1:0] addr;
		logic                   is_32bit;
		logic                   m_mode;
	} pmp_fetch_q_t;

	// load/store query
	typedef struct packed {
		logic                   req;
		logic [`PMP_W_ADDR-1:0] addr;
		logic                   write;
		logic                   m_mode;
	} pmp_data_q_t;

	// captured first fault, readable through the csr port
	typedef struct packed {
		logic                   valid;
		logic                   is_fetch;
		logic [`PMP_W_ADDR-1:0] addr;
	} pmp_fault_rec_t;

endpackage

`default_nettype wire

//--- include/pmp_cfg.svh
// pmp checker configuration: region count, datapath widths and csr map
`ifndef PMP_CFG_SVH
`define PMP_CFG_SVH

// ----------------------------------------
// sizes

// number of protection regions, kept a multiple of four so pmpcfg words fill up
`define PMP_REGIONS 8

// physical address width seen by both query ports
`define PMP_W_ADDR 32

// width of one csr data word
`define PMP_W_DATA 32

// width of the saturating fault counter
`define PMP_CNT_W 16

// ----------------------------------------
// csr addresses

// first pmpcfg word, each word carries four region bytes
`define PMP_CSR_PMPCFG0 12'h3A0
// first pmpaddr word, one word per region
`define PMP_CSR_PMPADDR0 12'h3B0

// fault bookkeeping, any write to info or count clears that block
`define PMP_CSR_FAULT_ADDR 12'hBC0
`define PMP_CSR_FAULT_INFO 12'hBC1
`define PMP_CSR_FAULT_CNT 12'hBC2

`endif
